// File: design/soc_pkg.sv
package soc_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // bus widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int XLEN     = 32;                  // data and address width
    localparam int BE_W     = XLEN / 8;            // byte lanes per word
    localparam int REGION_W = 4;                   // region code from the top address bits

    ////////////////////////////////////////////////////////////////////////////
    // address map, region taken from addr[31:28]
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [REGION_W-1:0] REGION_RAM_LIMIT   = 4'd2;  // regions 0..1 hit the RAM
    localparam logic [REGION_W-1:0] REGION_TIMER_LIMIT = 4'd8;  // regions 2..7 hit the timer
    // regions 8..15 fall through to the I/O block

    ////////////////////////////////////////////////////////////////////////////
    // machine timer offsets, addr[3:0]
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [3:0] TMR_MTIME_LO = 4'h0;
    localparam logic [3:0] TMR_MTIME_HI = 4'h4;
    localparam logic [3:0] TMR_CMP_LO   = 4'h8;
    localparam logic [3:0] TMR_CMP_HI   = 4'hC;

    ////////////////////////////////////////////////////////////////////////////
    // I/O block offsets, addr[7:0]
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [7:0] IO_GPIO_DATA = 8'h00;   // gpio output byte
    localparam logic [7:0] IO_GPIO_ADDR = 8'h04;   // gpio address byte
    localparam logic [7:0] IO_UART_DATA = 8'h10;   // write starts a frame
    localparam logic [7:0] IO_UART_STAT = 8'h14;   // bit 0 is busy
    localparam logic [7:0] IO_IRQ_PEND  = 8'h20;   // bit 0 is the button, write 1 to clear
    localparam logic [7:0] IO_IRQ_EN    = 8'h24;   // bit 0 enables the button irq

endpackage

// File: design/mem_bus_if.sv
`timescale 1ns/1ps

// one-cycle enable, read data returned in the following cycle
interface mem_bus_if
    import soc_pkg::*;
();

    logic            en;     // access strobe, one cycle
    logic [BE_W-1:0] we;     // byte write lanes, all low for a read
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] rdata;  // registered by the target

    modport initiator (
        output en, we, addr, wdata,
        input  rdata
    );

    modport target (
        input  en, we, addr, wdata,
        output rdata
    );

endinterface

// File: design/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder
    import soc_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                bus_en_i,
    input  logic [BE_W-1:0]     bus_we_i,
    input  logic [XLEN-1:0]     bus_addr_i,
    input  logic [XLEN-1:0]     bus_wdata_i,
    output logic [XLEN-1:0]     bus_rdata_o,
    mem_bus_if.initiator        ram_bus,
    mem_bus_if.initiator        tmr_bus,
    mem_bus_if.initiator        io_bus
);

    logic [REGION_W-1:0] region;
    logic                sel_ram;
    logic                sel_tmr;
    logic                sel_io;
    logic                sel_ram_q;
    logic                sel_tmr_q;
    logic                sel_io_q;

    assign region = bus_addr_i[XLEN-1 -: REGION_W];

    ////////////////////////////////////////////////////////////////////////////
    // region decode, exactly one target per access
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        sel_ram = 1'b0;
        sel_tmr = 1'b0;
        sel_io  = 1'b0;
        if (bus_en_i) begin
            if (region < REGION_RAM_LIMIT) begin
                sel_ram = 1'b1;
            end else if (region < REGION_TIMER_LIMIT) begin
                sel_tmr = 1'b1;
            end else begin
                sel_io = 1'b1;
            end
        end
    end

    assign ram_bus.en    = sel_ram;
    assign ram_bus.we    = bus_we_i;
    assign ram_bus.addr  = bus_addr_i;
    assign ram_bus.wdata = bus_wdata_i;

    assign tmr_bus.en    = sel_tmr;
    assign tmr_bus.we    = bus_we_i;
    assign tmr_bus.addr  = bus_addr_i;
    assign tmr_bus.wdata = bus_wdata_i;

    assign io_bus.en     = sel_io;
    assign io_bus.we     = bus_we_i;
    assign io_bus.addr   = bus_addr_i;
    assign io_bus.wdata  = bus_wdata_i;

    ////////////////////////////////////////////////////////////////////////////
    // read return, one cycle behind the access
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sel_ram_q <= 1'b0;
            sel_tmr_q <= 1'b0;
            sel_io_q  <= 1'b0;
        end else begin
            sel_ram_q <= sel_ram;  // all low after a cycle with no access
            sel_tmr_q <= sel_tmr;
            sel_io_q  <= sel_io;
        end
    end

    always_comb begin
        if (sel_ram_q) begin
            bus_rdata_o = ram_bus.rdata;
        end else if (sel_tmr_q) begin
            bus_rdata_o = tmr_bus.rdata;
        end else if (sel_io_q) begin
            bus_rdata_o = io_bus.rdata;
        end else begin
            bus_rdata_o = '0;
        end
    end

endmodule

// File: design/data_ram.sv
`timescale 1ns/1ps

module data_ram
    import soc_pkg::*;
#(
    parameter int RAM_WORDS = 1024
) (
    input  logic      clk,
    mem_bus_if.target bus
);

    localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    logic [XLEN-1:0]   mem [RAM_WORDS];
    logic [XLEN-3:0]   word_addr;
    logic [IDX_W-1:0]  word_idx;

    // byte address to word index, wraps at the array depth
    assign word_addr = bus.addr[XLEN-1:2];
    assign word_idx  = IDX_W'(word_addr % RAM_WORDS);

    ////////////////////////////////////////////////////////////////////////////
    // write lanes and synchronous read
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (bus.en) begin
            for (int b = 0; b < BE_W; b++) begin
                if (bus.we[b]) begin
                    mem[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8];  // one lane per we bit
                end
            end
            bus.rdata <= mem[word_idx];  // old word on a write cycle
        end
    end

endmodule

// File: design/machine_timer.sv
`timescale 1ns/1ps

module machine_timer
    import soc_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n_i,
    mem_bus_if.target bus,
    output logic      timer_irq_o
);

    logic [63:0] mtime_q;
    logic [63:0] mtime_d;
    logic [63:0] mtimecmp_q;
    logic [3:0]  offset;
    logic        wr;
    logic        rd;
    logic        timer_irq_q;

    assign offset = bus.addr[3:0];
    assign wr     = bus.en & (|bus.we);  // any lane means a full word
    assign rd     = bus.en & ~(|bus.we);

    ////////////////////////////////////////////////////////////////////////////
    // mtime next value
    ////////////////////////////////////////////////////////////////////////////

    // a write loads its half and skips the increment on that edge
    always_comb begin
        mtime_d = mtime_q + 64'd1;
        if (wr && offset == TMR_MTIME_LO) begin
            mtime_d = {mtime_q[63:32], bus.wdata};
        end else if (wr && offset == TMR_MTIME_HI) begin
            mtime_d = {bus.wdata, mtime_q[31:0]};
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mtime_q     <= '0;
            mtimecmp_q  <= '1;  // no interrupt until software sets a compare
            timer_irq_q <= 1'b0;
        end else begin
            mtime_q <= mtime_d;
            if (wr && offset == TMR_CMP_LO) begin
                mtimecmp_q[31:0] <= bus.wdata;
            end
            if (wr && offset == TMR_CMP_HI) begin
                mtimecmp_q[63:32] <= bus.wdata;
            end
            timer_irq_q <= (mtime_q >= mtimecmp_q);
        end
    end

    assign timer_irq_o = timer_irq_q;

    ////////////////////////////////////////////////////////////////////////////
    // register read, data ready one cycle later
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rd) begin
            case (offset)
                TMR_MTIME_LO: bus.rdata <= mtime_d[31:0];   // value as of this edge
                TMR_MTIME_HI: bus.rdata <= mtime_d[63:32];
                TMR_CMP_LO:   bus.rdata <= mtimecmp_q[31:0];
                TMR_CMP_HI:   bus.rdata <= mtimecmp_q[63:32];
                default:      bus.rdata <= '0;
            endcase
        end
    end

endmodule

// File: design/io_peripherals.sv
`timescale 1ns/1ps

module io_peripherals
    import soc_pkg::*;
#(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic       btn_i,
    input  logic       irq_ack_i,
    mem_bus_if.target  bus,
    output logic       stall_o,
    output logic [7:0] gpio_data_o,
    output logic [7:0] gpio_addr_o,
    output logic       uart_tx_o,
    output logic       ext_irq_o
);

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    logic [7:0]       offset;
    logic             acc;
    logic             wr;
    logic             rd;
    logic [7:0]       gpio_data_q;
    logic [7:0]       gpio_addr_q;
    logic [1:0]       btn_sync_q;
    logic             btn_prev_q;
    logic             btn_rise;
    logic             pend_clr;
    logic             irq_pend_q;
    logic             irq_en_q;
    logic             ext_irq_q;
    logic             busy_q;
    logic             tx_q;
    logic [8:0]       shift_q;
    logic [3:0]       bit_cnt_q;
    logic [CNT_W-1:0] clk_cnt_q;
    logic             bit_end;

    // accesses during a transmission are dropped
    assign offset = bus.addr[7:0];
    assign acc    = bus.en & ~busy_q;
    assign wr     = acc & (|bus.we);
    assign rd     = acc & ~(|bus.we);

    ////////////////////////////////////////////////////////////////////////////
    // gpio and interrupt registers
    ////////////////////////////////////////////////////////////////////////////

    assign btn_rise = btn_sync_q[1] & ~btn_prev_q;
    assign pend_clr = irq_ack_i | (wr && offset == IO_IRQ_PEND && bus.wdata[0]);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            gpio_data_q <= '0;
            gpio_addr_q <= '0;
            btn_sync_q  <= '0;
            btn_prev_q  <= 1'b0;
            irq_pend_q  <= 1'b0;
            irq_en_q    <= 1'b0;
            ext_irq_q   <= 1'b0;
        end else begin
            btn_sync_q <= {btn_sync_q[0], btn_i};  // two-flop synchroniser
            btn_prev_q <= btn_sync_q[1];
            if (wr && offset == IO_GPIO_DATA) begin
                gpio_data_q <= bus.wdata[7:0];
            end
            if (wr && offset == IO_GPIO_ADDR) begin
                gpio_addr_q <= bus.wdata[7:0];
            end
            if (wr && offset == IO_IRQ_EN) begin
                irq_en_q <= bus.wdata[0];
            end
            if (btn_rise) begin
                irq_pend_q <= 1'b1;  // new edge beats a clear
            end else if (pend_clr) begin
                irq_pend_q <= 1'b0;
            end
            ext_irq_q <= irq_pend_q & irq_en_q;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // uart transmitter, 8N1
    ////////////////////////////////////////////////////////////////////////////

    assign bit_end = (clk_cnt_q == CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q    <= 1'b0;
            tx_q      <= 1'b1;  // idle line
            bit_cnt_q <= '0;
            clk_cnt_q <= '0;
        end else if (!busy_q) begin
            if (wr && offset == IO_UART_DATA) begin
                busy_q    <= 1'b1;
                tx_q      <= 1'b0;  // start bit
                bit_cnt_q <= '0;
                clk_cnt_q <= '0;
            end
        end else if (bit_end) begin
            clk_cnt_q <= '0;
            if (bit_cnt_q == 4'd9) begin
                busy_q <= 1'b0;  // stop bit done
            end else begin
                tx_q      <= shift_q[0];
                bit_cnt_q <= bit_cnt_q + 4'd1;
            end
        end else begin
            clk_cnt_q <= clk_cnt_q + CNT_W'(1);
        end
    end

    // data bits lsb first, stop bit sits above them
    always_ff @(posedge clk) begin
        if (!busy_q && wr && offset == IO_UART_DATA) begin
            shift_q <= {1'b1, bus.wdata[7:0]};
        end else if (busy_q && bit_end) begin
            shift_q <= {1'b1, shift_q[8:1]};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // register read
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rd) begin
            case (offset)
                IO_GPIO_DATA: bus.rdata <= {{(XLEN-8){1'b0}}, gpio_data_q};
                IO_GPIO_ADDR: bus.rdata <= {{(XLEN-8){1'b0}}, gpio_addr_q};
                IO_UART_STAT: bus.rdata <= {{(XLEN-1){1'b0}}, busy_q};
                IO_IRQ_PEND:  bus.rdata <= {{(XLEN-1){1'b0}}, irq_pend_q};
                IO_IRQ_EN:    bus.rdata <= {{(XLEN-1){1'b0}}, irq_en_q};
                default:      bus.rdata <= '0;  // uart data is write-only
            endcase
        end
    end

    assign stall_o     = busy_q;
    assign gpio_data_o = gpio_data_q;
    assign gpio_addr_o = gpio_addr_q;
    assign uart_tx_o   = tx_q;
    assign ext_irq_o   = ext_irq_q;

endmodule

// File: design/soc_top.sv
`timescale 1ns/1ps

module soc_top
    import soc_pkg::*;
#(
    parameter int RAM_WORDS    = 1024,
    parameter int CLKS_PER_BIT = 868
) (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            bus_en_i,
    input  logic [BE_W-1:0] bus_we_i,
    input  logic [XLEN-1:0] bus_addr_i,
    input  logic [XLEN-1:0] bus_wdata_i,
    input  logic            btn_i,
    input  logic            irq_ack_i,
    output logic [XLEN-1:0] bus_rdata_o,
    output logic            bus_stall_o,
    output logic [7:0]      gpio_data_o,
    output logic [7:0]      gpio_addr_o,
    output logic            uart_tx_o,
    output logic            timer_irq_o,
    output logic            ext_irq_o
);

    mem_bus_if ram_bus ();  // decoder to data ram
    mem_bus_if tmr_bus ();  // decoder to machine timer
    mem_bus_if io_bus ();   // decoder to i/o block

    ////////////////////////////////////////////////////////////////////////////
    // address decode and read return
    ////////////////////////////////////////////////////////////////////////////

    bus_decoder bus_decoder_inst (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .bus_en_i    (bus_en_i),
        .bus_we_i    (bus_we_i),
        .bus_addr_i  (bus_addr_i),
        .bus_wdata_i (bus_wdata_i),
        .bus_rdata_o (bus_rdata_o),
        .ram_bus     (ram_bus),
        .tmr_bus     (tmr_bus),
        .io_bus      (io_bus)
    );

    ////////////////////////////////////////////////////////////////////////////
    // targets
    ////////////////////////////////////////////////////////////////////////////

    data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) data_ram_inst (
        .clk (clk),
        .bus (ram_bus)
    );

    machine_timer machine_timer_inst (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .bus         (tmr_bus),
        .timer_irq_o (timer_irq_o)
    );

    io_peripherals #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) io_peripherals_inst (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .btn_i       (btn_i),
        .irq_ack_i   (irq_ack_i),
        .bus         (io_bus),
        .stall_o     (bus_stall_o),  // uart busy holds off the master
        .gpio_data_o (gpio_data_o),
        .gpio_addr_o (gpio_addr_o),
        .uart_tx_o   (uart_tx_o),
        .ext_irq_o   (ext_irq_o)
    );

endmodule

// File: sim/soc_tb.sv
`timescale 1ns/1ps

module soc_tb
    import soc_pkg::*;
();

    localparam int CLKS_PER_BIT = 8;
    localparam int RAM_WORDS    = 256;
    localparam int ROWS_MAX     = 128;

    localparam logic [2:0] OP_WR   = 3'd0;
    localparam logic [2:0] OP_RD   = 3'd1;
    localparam logic [2:0] OP_IDLE = 3'd2;  // wait wdata cycles
    localparam logic [2:0] OP_CHK  = 3'd3;  // compare the output picked by addr
    localparam logic [2:0] OP_UART = 3'd4;  // data write plus frame check
    localparam logic [2:0] OP_BTN  = 3'd5;  // rising edge on the button
    localparam logic [2:0] OP_ACK  = 3'd6;  // one-cycle irq acknowledge

    localparam logic [31:0] SIG_TIRQ  = 32'd0;
    localparam logic [31:0] SIG_EIRQ  = 32'd1;
    localparam logic [31:0] SIG_GPIOD = 32'd2;
    localparam logic [31:0] SIG_GPIOA = 32'd3;

    logic            clk;
    logic            arst_n_i;
    logic            bus_en_i;
    logic [BE_W-1:0] bus_we_i;
    logic [XLEN-1:0] bus_addr_i;
    logic [XLEN-1:0] bus_wdata_i;
    logic            btn_i;
    logic            irq_ack_i;
    logic [XLEN-1:0] bus_rdata_o;
    logic            bus_stall_o;
    logic [7:0]      gpio_data_o;
    logic [7:0]      gpio_addr_o;
    logic            uart_tx_o;
    logic            timer_irq_o;
    logic            ext_irq_o;

    logic [2:0]  op_tab    [ROWS_MAX];
    logic [31:0] addr_tab  [ROWS_MAX];
    logic [31:0] wdata_tab [ROWS_MAX];
    logic [3:0]  be_tab    [ROWS_MAX];
    logic [31:0] exp_tab   [ROWS_MAX];
    logic        chk_tab   [ROWS_MAX];
    logic [31:0] ram_model [RAM_WORDS];  // scoreboard, one entry per word
    int          n_rows       = 0;
    int          cycle_cnt    = 0;
    int          limit_cycles = 100000;
    integer      seed         = 66;
    int          row;

    soc_top #(
        .RAM_WORDS    (RAM_WORDS),
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) soc_top_inst (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .bus_en_i    (bus_en_i),
        .bus_we_i    (bus_we_i),
        .bus_addr_i  (bus_addr_i),
        .bus_wdata_i (bus_wdata_i),
        .btn_i       (btn_i),
        .irq_ack_i   (irq_ack_i),
        .bus_rdata_o (bus_rdata_o),
        .bus_stall_o (bus_stall_o),
        .gpio_data_o (gpio_data_o),
        .gpio_addr_o (gpio_addr_o),
        .uart_tx_o   (uart_tx_o),
        .timer_irq_o (timer_irq_o),
        .ext_irq_o   (ext_irq_o)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= limit_cycles) begin
            $display("ERROR: simulation timed out after %0d cycles", cycle_cnt);
            $display("Finished with errors");
            $fatal(1, "timeout");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checking
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string name);
        if (actual !== expected) begin
            $display("[FAIL] time %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("Finished with errors");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] probe_value(input logic [31:0] sel);
        case (sel)
            SIG_TIRQ:  return {31'd0, timer_irq_o};
            SIG_EIRQ:  return {31'd0, ext_irq_o};
            SIG_GPIOD: return {24'd0, gpio_data_o};
            default:   return {24'd0, gpio_addr_o};
        endcase
    endfunction

    function automatic string probe_name(input logic [31:0] sel);
        case (sel)
            SIG_TIRQ:  return "timer_irq_o";
            SIG_EIRQ:  return "ext_irq_o";
            SIG_GPIOD: return "gpio_data_o";
            default:   return "gpio_addr_o";
        endcase
    endfunction

    // called at the negedge after the write edge, bit k centred 8k+4 edges later
    task automatic check_frame(input logic [7:0] data);
        int   n;
        int   k;
        logic exp_bit;
        n = 0;
        check_value({31'd0, bus_stall_o}, 32'd1, "bus_stall_o");
        for (k = 0; k < 10; k++) begin
            while (n < k * CLKS_PER_BIT + CLKS_PER_BIT / 2) begin
                @(posedge clk);
                n++;
            end
            #2;
            if (k == 0) exp_bit = 1'b0;        // start
            else if (k == 9) exp_bit = 1'b1;   // stop
            else exp_bit = data[k-1];          // lsb first
            check_value({31'd0, uart_tx_o}, {31'd0, exp_bit}, "uart_tx_o");
        end
        while (n < 10 * CLKS_PER_BIT + 1) begin
            @(posedge clk);
            n++;
        end
        #2;
        check_value({31'd0, bus_stall_o}, 32'd0, "bus_stall_o");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////////////////////////////////////////

    task automatic add_row(input logic [2:0] op, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [3:0] be,
                           input logic [31:0] exp, input logic chk);
        op_tab[n_rows]    = op;
        addr_tab[n_rows]  = addr;
        wdata_tab[n_rows] = wdata;
        be_tab[n_rows]    = be;
        exp_tab[n_rows]   = exp;
        chk_tab[n_rows]   = chk;
        n_rows++;
    endtask

    // word index is addr[9:2] for 256 words, regions 0 and 1 alias
    task automatic ram_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] be);
        int b;
        for (b = 0; b < 4; b++) begin
            if (be[b]) ram_model[addr[9:2]][8*b +: 8] = data[8*b +: 8];
        end
        add_row(OP_WR, addr, data, be, 32'd0, 1'b0);
    endtask

    task automatic ram_read(input logic [31:0] addr);
        add_row(OP_RD, addr, 32'd0, 4'd0, ram_model[addr[9:2]], 1'b1);
    endtask

    task automatic build_table;
        logic [31:0] addr;
        logic [31:0] rnd;
        logic [3:0]  be;
        int          i;
        // decode, same offset in three regions
        ram_write(32'h1000_0008, 32'hCAFE_F00D, 4'hF);
        add_row(OP_WR, 32'h4000_0008, 32'h55AA_1234, 4'hF, 32'd0, 1'b0);  // mtimecmp lo
        add_row(OP_WR, 32'h8000_0008, 32'hFFFF_FFFF, 4'hF, 32'd0, 1'b0);  // unmapped io
        ram_read(32'h1000_0008);
        ram_read(32'h0000_0008);
        add_row(OP_RD, 32'h4000_0008, 32'd0, 4'd0, 32'h55AA_1234, 1'b1);
        add_row(OP_RD, 32'h8000_0008, 32'd0, 4'd0, 32'd0, 1'b1);
        add_row(OP_RD, 32'h2000_000C, 32'd0, 4'd0, 32'hFFFF_FFFF, 1'b1);  // cmp hi reset
        add_row(OP_RD, 32'hF000_0030, 32'd0, 4'd0, 32'd0, 1'b1);
        // ram byte lanes on random words
        for (i = 0; i < 6; i++) begin
            addr = $random(seed);
            addr = addr & 32'h1000_03FC;
            ram_write(addr, $random(seed), 4'hF);
            ram_read(addr);
            rnd = $random(seed);
            be  = rnd[3:0];
            if (be == 4'h0 || be == 4'hF) be = 4'b0110;
            ram_write(addr, $random(seed), be);
            ram_read(addr);
        end
        // mtime: lo written at edge E reads back 8 edges later as value + 8
        add_row(OP_WR, 32'h4000_0004, 32'h0000_0002, 4'hF, 32'd0, 1'b0);
        add_row(OP_WR, 32'h4000_0000, 32'h1000_0000, 4'hF, 32'd0, 1'b0);
        add_row(OP_IDLE, 32'd0, 32'd5, 4'd0, 32'd0, 1'b0);
        add_row(OP_RD, 32'h4000_0000, 32'd0, 4'd0, 32'h1000_0008, 1'b1);
        add_row(OP_RD, 32'h4000_0004, 32'd0, 4'd0, 32'h0000_0002, 1'b1);
        // mtime lo = 0 at edge W, compare 2:40 complete at W+4, irq from W+41
        add_row(OP_WR, 32'h4000_0000, 32'd0, 4'hF, 32'd0, 1'b0);
        add_row(OP_WR, 32'h4000_0008, 32'd40, 4'hF, 32'd0, 1'b0);
        add_row(OP_WR, 32'h4000_000C, 32'd2, 4'hF, 32'd0, 1'b0);
        add_row(OP_CHK, SIG_TIRQ, 32'd0, 4'd0, 32'd0, 1'b1);             // W+5
        add_row(OP_IDLE, 32'd0, 32'd30, 4'd0, 32'd0, 1'b0);
        add_row(OP_CHK, SIG_TIRQ, 32'd0, 4'd0, 32'd0, 1'b1);             // W+37
        add_row(OP_IDLE, 32'd0, 32'd6, 4'd0, 32'd0, 1'b0);
        add_row(OP_CHK, SIG_TIRQ, 32'd0, 4'd0, 32'd1, 1'b1);             // W+45
        add_row(OP_WR, 32'h4000_000C, 32'd3, 4'hF, 32'd0, 1'b0);
        add_row(OP_IDLE, 32'd0, 32'd2, 4'd0, 32'd0, 1'b0);
        add_row(OP_CHK, SIG_TIRQ, 32'd0, 4'd0, 32'd0, 1'b1);
        // gpio, any lane writes byte 0
        add_row(OP_WR, 32'h8000_0000, 32'h1234_56A5, 4'hF, 32'd0, 1'b0);
        add_row(OP_CHK, SIG_GPIOD, 32'd0, 4'd0, 32'h0000_00A5, 1'b1);
        add_row(OP_WR, 32'hC000_0004, 32'h0000_003C, 4'b1000, 32'd0, 1'b0);
        add_row(OP_CHK, SIG_GPIOA, 32'd0, 4'd0, 32'h0000_003C, 1'b1);
        add_row(OP_RD, 32'h8000_0000, 32'd0, 4'd0, 32'h0000_00A5, 1'b1);
        add_row(OP_RD, 32'h8000_0004, 32'd0, 4'd0, 32'h0000_003C, 1'b1);
        // uart frames; the read after a plain write must wait out the stall
        add_row(OP_UART, 32'h8000_0010, $random(seed), 4'hF, 32'd0, 1'b1);
        add_row(OP_UART, 32'h8000_0010, $random(seed), 4'hF, 32'd0, 1'b1);
        add_row(OP_WR, 32'h8000_0010, 32'h0000_005A, 4'hF, 32'd0, 1'b0);
        add_row(OP_RD, 32'h8000_0014, 32'd0, 4'd0, 32'd0, 1'b1);
        // button irq
        add_row(OP_WR, 32'h8000_0024, 32'd0, 4'hF, 32'd0, 1'b0);
        add_row(OP_BTN, 32'd0, 32'd0, 4'd0, 32'd0, 1'b0);
        add_row(OP_RD, 32'h8000_0020, 32'd0, 4'd0, 32'd1, 1'b1);
        add_row(OP_CHK, SIG_EIRQ, 32'd0, 4'd0, 32'd0, 1'b1);             // masked
        add_row(OP_WR, 32'h8000_0024, 32'd1, 4'hF, 32'd0, 1'b0);
        add_row(OP_IDLE, 32'd0, 32'd0, 4'd0, 32'd0, 1'b0);
        add_row(OP_CHK, SIG_EIRQ, 32'd0, 4'd0, 32'd1, 1'b1);             // 2 edges after enable
        add_row(OP_ACK, 32'd0, 32'd0, 4'd0, 32'd0, 1'b0);
        add_row(OP_CHK, SIG_EIRQ, 32'd0, 4'd0, 32'd0, 1'b1);
        add_row(OP_RD, 32'h8000_0020, 32'd0, 4'd0, 32'd0, 1'b1);
        add_row(OP_BTN, 32'd0, 32'd0, 4'd0, 32'd0, 1'b0);
        add_row(OP_RD, 32'h8000_0020, 32'd0, 4'd0, 32'd1, 1'b1);
        add_row(OP_CHK, SIG_EIRQ, 32'd0, 4'd0, 32'd1, 1'b1);
        add_row(OP_WR, 32'h8000_0020, 32'd1, 4'hF, 32'd0, 1'b0);         // write 1 to clear
        add_row(OP_RD, 32'h8000_0020, 32'd0, 4'd0, 32'd0, 1'b1);
        add_row(OP_CHK, SIG_EIRQ, 32'd0, 4'd0, 32'd0, 1'b1);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // row execution, each row starts 2 ns after a rising edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic apply_row(input int i);
        @(posedge clk);
        #2;
        case (op_tab[i])
            OP_WR, OP_RD, OP_UART: begin
                while (bus_stall_o) begin
                    @(posedge clk);
                    #2;
                end
                bus_en_i    = 1'b1;
                bus_we_i    = be_tab[i];
                bus_addr_i  = addr_tab[i];
                bus_wdata_i = wdata_tab[i];
                @(posedge clk);  // access edge
                #2;
                bus_en_i = 1'b0;
                bus_we_i = '0;
                @(negedge clk);
                if (op_tab[i] == OP_RD && chk_tab[i]) begin
                    check_value(bus_rdata_o, exp_tab[i], "bus_rdata_o");
                end
                if (op_tab[i] == OP_UART) check_frame(wdata_tab[i][7:0]);
            end
            OP_IDLE: repeat (wdata_tab[i]) @(posedge clk);
            OP_CHK: begin
                check_value(probe_value(addr_tab[i]), exp_tab[i], probe_name(addr_tab[i]));
            end
            OP_BTN: begin
                btn_i = 1'b1;
                repeat (4) @(posedge clk);
                #2;
                btn_i = 1'b0;
            end
            default: begin
                irq_ack_i = 1'b1;
                @(posedge clk);
                #2;
                irq_ack_i = 1'b0;
            end
        endcase
    endtask

    initial begin
        clk         = 1'b0;
        arst_n_i    = 1'b0;
        bus_en_i    = 1'b0;
        bus_we_i    = '0;
        bus_addr_i  = '0;
        bus_wdata_i = '0;
        btn_i       = 1'b0;
        irq_ack_i   = 1'b0;
        build_table();
        limit_cycles = n_rows * (10 * CLKS_PER_BIT + 4) + 400;
        repeat (10) @(posedge clk);
        #2;
        arst_n_i = 1'b1;
        for (row = 0; row < n_rows; row++) begin
            apply_row(row);
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: all.f
design/soc_pkg.sv
design/mem_bus_if.sv
design/bus_decoder.sv
design/data_ram.sv
design/machine_timer.sv
design/io_peripherals.sv
design/soc_top.sv
sim/soc_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the soc testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing -Wno-fatal -f all.f --top-module soc_tb \
    -Mdir "$BUILD_DIR" -o soc_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/soc_tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Finished with no errors$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi
